// ==== verilog/lbp_settings.svh ====
`ifndef LBP_SETTINGS_SVH
`define LBP_SETTINGS_SVH

// Grayscale sample width.
`define LBP_PIX_W 8

// Default frame size.
`define LBP_COLS 30
`define LBP_ROWS 30

// Window side and neighbors per ring.
`define LBP_WIN 5
`define LBP_NUM_NB 8

// Pixels in the 5x5 patch.
`define LBP_PATCH_GAIN 25

`define LBP_RIU2_NONUNIFORM 9

`endif

// ==== verilog/lbp_pkg.sv ====
`include "lbp_settings.svh"

package lbp_pkg;

  typedef logic [`LBP_PIX_W-1:0] pixel_t;

  // Row by row, top-left pixel at index 0.
  typedef logic [`LBP_WIN*`LBP_WIN*`LBP_PIX_W-1:0] window_t;

  typedef logic [`LBP_NUM_NB-1:0] pattern_t;

  typedef logic [$clog2(`LBP_PATCH_GAIN*(2**`LBP_PIX_W-1)+1)-1:0] patch_sum_t;

  typedef logic [3:0] riu2_t;

  typedef struct packed {
    riu2_t rd;
    riu2_t ni;
  } lbp_code_t;

  // Steps of neighbor k, counter-clockwise from east.
  localparam int NB_DR [`LBP_NUM_NB] = '{0, -1, -1, -1, 0, 1, 1, 1};
  localparam int NB_DC [`LBP_NUM_NB] = '{1, 1, 0, -1, -1, -1, 0, 1};

  // Window index of neighbor k on the given ring.
  function automatic int nb_index(int k, int radius);
    return (`LBP_WIN / 2 + radius * NB_DR[k]) * `LBP_WIN + `LBP_WIN / 2 + radius * NB_DC[k];
  endfunction

endpackage

// ==== verilog/line_window_5x5.sv ====
`timescale 1ns/1ps
`include "lbp_settings.svh"

module line_window_5x5 #(
  parameter int COLS = `LBP_COLS,
  parameter int ROWS = `LBP_ROWS
) (
  input  logic             clk,
  input  logic             rst_n_i,
  input  lbp_pkg::pixel_t  pix_i,
  input  logic             pix_valid_i,
  output lbp_pkg::window_t win_o,
  output logic             win_valid_o
);
  import lbp_pkg::*;

  localparam int LINES = `LBP_WIN - 1;
  localparam int CW = $clog2(COLS);
  localparam int RW = $clog2(ROWS);

  pixel_t        line_mem [LINES][COLS];  // Line 0 is the row just above.
  pixel_t        win_q [`LBP_WIN][`LBP_WIN];
  pixel_t        col_new [`LBP_WIN];
  logic [CW-1:0] col_q;
  logic [RW-1:0] row_q;
  logic          last_col;
  logic          win_valid_q;

  // Incoming column, oldest line on top.
  always_comb begin
    for (int r = 0; r < LINES; r++) begin
      col_new[r] = line_mem[LINES - 1 - r][col_q];
    end
    col_new[LINES] = pix_i;
  end

  always_ff @(posedge clk) begin
    if (pix_valid_i) begin
      line_mem[0][col_q] <= pix_i;
      for (int l = 1; l < LINES; l++) begin
        line_mem[l][col_q] <= line_mem[l - 1][col_q];  // Age lines by one row.
      end
      for (int r = 0; r < `LBP_WIN; r++) begin
        for (int c = 0; c < `LBP_WIN - 1; c++) begin
          win_q[r][c] <= win_q[r][c + 1];
        end
        win_q[r][`LBP_WIN - 1] <= col_new[r];
      end
    end
  end

  assign last_col = (col_q == CW'(COLS - 1));

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      col_q       <= '0;
      row_q       <= '0;
      win_valid_q <= 1'b0;
    end else begin
      // Full window only once four lines and four columns are behind.
      win_valid_q <= pix_valid_i && (row_q >= RW'(LINES)) && (col_q >= CW'(LINES));
      if (pix_valid_i) begin
        if (last_col) begin
          col_q <= '0;
          if (row_q == RW'(ROWS - 1)) begin
            row_q <= '0;  // End of frame.
          end else begin
            row_q <= row_q + 1'b1;
          end
        end else begin
          col_q <= col_q + 1'b1;
        end
      end
    end
  end

  always_comb begin
    for (int r = 0; r < `LBP_WIN; r++) begin
      for (int c = 0; c < `LBP_WIN; c++) begin
        win_o[(r * `LBP_WIN + c) * `LBP_PIX_W +: `LBP_PIX_W] = win_q[r][c];
      end
    end
  end

  assign win_valid_o = win_valid_q;

endmodule

// ==== verilog/rd_pattern.sv ====
`timescale 1ns/1ps
`include "lbp_settings.svh"

module rd_pattern (
  input  logic              clk,
  input  logic              rst_n_i,
  input  lbp_pkg::window_t  win_i,
  input  logic              win_valid_i,
  output lbp_pkg::pattern_t pattern_o,
  output logic              pattern_valid_o
);
  import lbp_pkg::*;

  pixel_t   ring1 [`LBP_NUM_NB];
  pixel_t   ring2 [`LBP_NUM_NB];
  pattern_t pattern_d;
  pattern_t pattern_q;
  logic     valid_q;

  for (genvar k = 0; k < `LBP_NUM_NB; k++) begin : g_ring
    assign ring1[k] = win_i[nb_index(k, 1) * `LBP_PIX_W +: `LBP_PIX_W];
    assign ring2[k] = win_i[nb_index(k, 2) * `LBP_PIX_W +: `LBP_PIX_W];
    assign pattern_d[k] = (ring2[k] >= ring1[k]);  // Outer ring against inner.
  end

  always_ff @(posedge clk) begin
    if (win_valid_i) begin
      pattern_q <= pattern_d;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= win_valid_i;
    end
  end

  assign pattern_o       = pattern_q;
  assign pattern_valid_o = valid_q;

endmodule

// ==== verilog/ni_pattern.sv ====
`timescale 1ns/1ps
`include "lbp_settings.svh"

module ni_pattern (
  input  logic              clk,
  input  logic              rst_n_i,
  input  lbp_pkg::window_t  win_i,
  input  logic              win_valid_i,
  output lbp_pkg::pattern_t pattern_o,
  output logic              pattern_valid_o
);
  import lbp_pkg::*;

  patch_sum_t row_sum [`LBP_WIN];
  patch_sum_t patch_sum;
  patch_sum_t scaled [`LBP_NUM_NB];
  pixel_t     ring2 [`LBP_NUM_NB];
  pattern_t   pattern_d;
  pattern_t   pattern_q;
  logic       valid_q;

  // Row sums first, then the five rows.
  always_comb begin
    for (int r = 0; r < `LBP_WIN; r++) begin
      row_sum[r] = '0;
      for (int c = 0; c < `LBP_WIN; c++) begin
        row_sum[r] = row_sum[r]
                   + patch_sum_t'(win_i[(r * `LBP_WIN + c) * `LBP_PIX_W +: `LBP_PIX_W]);
      end
    end
  end

  always_comb begin
    patch_sum = '0;
    for (int r = 0; r < `LBP_WIN; r++) begin
      patch_sum = patch_sum + row_sum[r];
    end
  end

  // Gain-scaled sample versus the sum, same as sample versus mean.
  for (genvar k = 0; k < `LBP_NUM_NB; k++) begin : g_nb
    assign ring2[k]     = win_i[nb_index(k, 2) * `LBP_PIX_W +: `LBP_PIX_W];
    assign scaled[k]    = patch_sum_t'(ring2[k]) * patch_sum_t'(`LBP_PATCH_GAIN);
    assign pattern_d[k] = (scaled[k] >= patch_sum);
  end

  always_ff @(posedge clk) begin
    if (win_valid_i) begin
      pattern_q <= pattern_d;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= win_valid_i;
    end
  end

  assign pattern_o       = pattern_q;
  assign pattern_valid_o = valid_q;

endmodule

// ==== verilog/riu2_combine.sv ====
`timescale 1ns/1ps
`include "lbp_settings.svh"

module riu2_combine (
  input  logic               clk,
  input  logic               rst_n_i,
  input  lbp_pkg::pattern_t  rd_pattern_i,
  input  lbp_pkg::pattern_t  ni_pattern_i,
  input  logic               pattern_valid_i,
  output lbp_pkg::lbp_code_t code_o,
  output logic               code_valid_o
);
  import lbp_pkg::*;

  lbp_code_t code_d;
  lbp_code_t code_q;
  logic      code_valid_q;

  // Popcount for uniform patterns, else the catch-all code.
  function automatic riu2_t riu2_map(pattern_t p);
    riu2_t      ones;
    logic [3:0] trans;
    ones  = '0;
    trans = '0;
    for (int k = 0; k < `LBP_NUM_NB; k++) begin
      ones  = ones + riu2_t'(p[k]);
      trans = trans + 4'(p[k] ^ p[(k + 1) % `LBP_NUM_NB]);  // Circular neighbor.
    end
    if (trans <= 4'd2) begin
      return ones;
    end
    return riu2_t'(`LBP_RIU2_NONUNIFORM);
  endfunction

  always_comb begin
    code_d.rd = riu2_map(rd_pattern_i);
    code_d.ni = riu2_map(ni_pattern_i);
  end

  always_ff @(posedge clk) begin
    if (pattern_valid_i) begin
      code_q <= code_d;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      code_valid_q <= 1'b0;
    end else begin
      code_valid_q <= pattern_valid_i;
    end
  end

  assign code_o       = code_q;
  assign code_valid_o = code_valid_q;

endmodule

// ==== verilog/lbp_top.sv ====
`timescale 1ns/1ps
`include "lbp_settings.svh"

module lbp_top #(
  parameter int COLS = `LBP_COLS,
  parameter int ROWS = `LBP_ROWS
) (
  input  logic               clk,
  input  logic               rst_n_i,
  input  lbp_pkg::pixel_t    pix_i,
  input  logic               pix_valid_i,
  output lbp_pkg::lbp_code_t code_o,
  output logic               code_valid_o
);
  import lbp_pkg::*;

  window_t  win;
  logic     win_valid;
  pattern_t rd_pat;
  pattern_t ni_pat;
  logic     rd_valid;

  line_window_5x5 #(
    .COLS(COLS),
    .ROWS(ROWS)
  ) u_window (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .pix_i      (pix_i),
    .pix_valid_i(pix_valid_i),
    .win_o      (win),
    .win_valid_o(win_valid)
  );

  rd_pattern u_rd (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .win_i          (win),
    .win_valid_i    (win_valid),
    .pattern_o      (rd_pat),
    .pattern_valid_o(rd_valid)
  );

  // Same latency as the rd part, so its strobe is not needed.
  ni_pattern u_ni (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .win_i          (win),
    .win_valid_i    (win_valid),
    .pattern_o      (ni_pat),
    .pattern_valid_o()
  );

  riu2_combine u_combine (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .rd_pattern_i   (rd_pat),
    .ni_pattern_i   (ni_pat),
    .pattern_valid_i(rd_valid),
    .code_o         (code_o),
    .code_valid_o   (code_valid_o)
  );

endmodule

// ==== tb/lbp_tb.sv ====
`timescale 1ns/1ps
`include "lbp_settings.svh"

module lbp_tb;
  import lbp_pkg::*;

  localparam int COLS         = 12;
  localparam int ROWS         = 10;
  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DELAY  = 10;
  localparam int RESET_CYCLES = 5;
  localparam int MAX_GAP      = 3;
  localparam int NUM_FRAMES   = 5;  // Flat, random, gapped, cut short, after reset.
  localparam int WATCHDOG_NS  = NUM_FRAMES * ROWS * COLS * (MAX_GAP + 1) * CLK_PERIOD * 2;
  localparam int EDGE         = `LBP_WIN / 2;
  localparam int FULL_COUNT   = (ROWS - 2 * EDGE) * (COLS - 2 * EDGE);

  // Neighbor steps counter-clockwise from east.
  localparam int OFF_R [`LBP_NUM_NB] = '{0, -1, -1, -1, 0, 1, 1, 1};
  localparam int OFF_C [`LBP_NUM_NB] = '{1, 1, 0, -1, -1, -1, 0, 1};

  logic      clk;
  logic      rst_n_i;
  pixel_t    pix_i;
  logic      pix_valid_i;
  lbp_code_t code_o;
  logic      code_valid_o;

  pixel_t    frame [ROWS][COLS];
  lbp_code_t exp_q [$];
  logic      qual;  // Pixel on the input completes a window.
  logic      chk_en;
  lbp_code_t chk_exp;
  lbp_code_t chk_act;
  string     test_name;
  int        errors;
  int        errors_at_start;
  int        out_count;
  int        tests_run;
  int        tests_failed;
  int        nonuniform_ni;

  lbp_top #(
    .COLS(COLS),
    .ROWS(ROWS)
  ) DUT (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .pix_i       (pix_i),
    .pix_valid_i (pix_valid_i),
    .code_o      (code_o),
    .code_valid_o(code_valid_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all tests finished");
    $display("** FAIL **");
    $finish;
  end

  function automatic riu2_t riu2_value(pattern_t p);
    int ones;
    int trans;
    ones  = 0;
    trans = 0;
    for (int k = 0; k < `LBP_NUM_NB; k++) begin
      ones += int'(p[k]);
      if (p[k] != p[(k + 1) % `LBP_NUM_NB]) begin
        trans++;
      end
    end
    if (trans > 2) begin
      return riu2_t'(`LBP_RIU2_NONUNIFORM);
    end
    return riu2_t'(ones);
  endfunction

  // Expected code for the window centered at (r, c).
  function automatic lbp_code_t model_code(int r, int c);
    pattern_t  rd;
    pattern_t  ni;
    int        sum;
    int        inner;
    int        outer;
    lbp_code_t code;
    sum = 0;
    for (int dr = -EDGE; dr <= EDGE; dr++) begin
      for (int dc = -EDGE; dc <= EDGE; dc++) begin
        sum += int'(frame[r + dr][c + dc]);
      end
    end
    for (int k = 0; k < `LBP_NUM_NB; k++) begin
      inner = int'(frame[r + OFF_R[k]][c + OFF_C[k]]);
      outer = int'(frame[r + 2 * OFF_R[k]][c + 2 * OFF_C[k]]);
      rd[k] = (outer >= inner);
      ni[k] = (`LBP_PATCH_GAIN * outer >= sum);
    end
    code.rd = riu2_value(rd);
    code.ni = riu2_value(ni);
    return code;
  endfunction

  task automatic fill_flat(input pixel_t value);
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        frame[r][c] = value;
      end
    end
  endtask

  task automatic fill_random();
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        frame[r][c] = pixel_t'($urandom);
      end
    end
  endtask

  // Called 10 ns after an edge; returns at the same phase.
  task automatic drive_pixel(input int r, input int c, input int gap);
    lbp_code_t exp;
    pix_i       = frame[r][c];
    pix_valid_i = 1'b1;
    qual        = (r >= `LBP_WIN - 1) && (c >= `LBP_WIN - 1);
    if (qual) begin
      exp = model_code(r - EDGE, c - EDGE);
      exp_q.push_back(exp);
      if (exp.ni == riu2_t'(`LBP_RIU2_NONUNIFORM)) begin
        nonuniform_ni++;
      end
    end
    @(posedge clk);
    #DRIVE_DELAY;
    pix_valid_i = 1'b0;
    qual        = 1'b0;
    repeat (gap) begin
      @(posedge clk);
      #DRIVE_DELAY;
    end
  endtask

  task automatic feed_rows(input int rows, input int max_gap);
    int gap;
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < COLS; c++) begin
        gap = (max_gap == 0) ? 0 : int'($urandom_range(max_gap, 0));
        drive_pixel(r, c, gap);
      end
    end
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = errors;
    out_count       = 0;
  endtask

  task automatic finish_test(input int exp_count);
    int new_errors;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);  // No stray results after the last one.
    #DRIVE_DELAY;
    count_check: assert (out_count == exp_count) else begin
      $display("mismatch %s output count expected %0d actual %0d",
               test_name, exp_count, out_count);
      errors++;
    end
    new_errors = errors - errors_at_start;
    tests_run++;
    if (new_errors == 0) begin
      $display("test %s passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", test_name, new_errors);
    end
  endtask

  // Latch each result mid-cycle for the value checks at the next edge.
  always @(negedge clk) begin
    chk_en = 1'b0;
    if (code_valid_o === 1'b1) begin
      out_count++;
      pending_check: assert (exp_q.size() != 0) else begin
        $display("test %s produced a result with none expected", test_name);
        errors++;
      end
      if (exp_q.size() != 0) begin
        chk_exp = exp_q.pop_front();
        chk_act = code_o;
        chk_en  = 1'b1;
      end
    end
  end

  rd_check: assert property (@(posedge clk) chk_en |-> (chk_act.rd == chk_exp.rd))
    else begin
      $display("mismatch %s rd expected %0d actual %0d", test_name, chk_exp.rd, chk_act.rd);
      errors++;
    end

  ni_check: assert property (@(posedge clk) chk_en |-> (chk_act.ni == chk_exp.ni))
    else begin
      $display("mismatch %s ni expected %0d actual %0d", test_name, chk_exp.ni, chk_act.ni);
      errors++;
    end

  // Result strobe three edges after the pixel that completed its window.
  latency_check: assert property (@(posedge clk) disable iff (!rst_n_i)
                                  code_valid_o == $past(qual, 3))
    else begin
      $display("test %s saw code_valid_o off its 3 cycle slot", test_name);
      errors++;
    end

  initial begin
    void'($urandom(19));
    rst_n_i         = 1'b0;
    pix_i           = '0;
    pix_valid_i     = 1'b0;
    qual            = 1'b0;
    chk_en          = 1'b0;
    chk_exp         = '0;
    chk_act         = '0;
    test_name       = "reset";
    errors          = 0;
    errors_at_start = 0;
    out_count       = 0;
    tests_run       = 0;
    tests_failed    = 0;
    nonuniform_ni   = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_n_i = 1'b1;

    start_test("idle_after_reset");
    repeat (20) @(posedge clk);
    finish_test(0);

    start_test("flat_frame");
    fill_flat(8'h5a);
    feed_rows(ROWS, 0);
    finish_test(FULL_COUNT);

    start_test("random_back_to_back");
    nonuniform_ni = 0;
    fill_random();
    feed_rows(ROWS, 0);
    nonuniform_check: assert (nonuniform_ni > 0) else begin
      $display("random frame held no non-uniform ni window");
      errors++;
    end
    finish_test(FULL_COUNT);

    start_test("random_gaps");
    fill_random();
    feed_rows(ROWS, MAX_GAP);
    finish_test(FULL_COUNT);

    start_test("mid_frame_reset");
    fill_random();
    feed_rows(ROWS / 2, 0);
    for (int c = 0; c < COLS - 1; c++) begin
      drive_pixel(ROWS / 2, c, 0);
    end
    // Reset lands while a qualifying pixel is on the input and the pipe is full.
    rst_n_i     = 1'b0;
    pix_i       = frame[ROWS / 2][COLS - 1];
    pix_valid_i = 1'b1;
    @(posedge clk);
    #DRIVE_DELAY;
    pix_valid_i = 1'b0;
    reset_clear_check: assert (!DUT.win_valid && !DUT.rd_valid && !code_valid_o) else begin
      $display("test %s found a valid output still high in reset", test_name);
      errors++;
    end
    repeat (RESET_CYCLES - 1) begin
      @(posedge clk);
      #DRIVE_DELAY;
    end
    exp_q.delete();  // Results in flight are lost.
    out_count = 0;
    rst_n_i   = 1'b1;
    fill_random();
    feed_rows(ROWS, 0);
    finish_test(FULL_COUNT);

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+verilog
verilog/lbp_pkg.sv
verilog/line_window_5x5.sv
verilog/rd_pattern.sv
verilog/ni_pattern.sv
verilog/riu2_combine.sv
verilog/lbp_top.sv
tb/lbp_tb.sv

// ==== Bender.yml ====
package:
  name: lbp

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/lbp_pkg.sv
      - verilog/line_window_5x5.sv
      - verilog/rd_pattern.sv
      - verilog/ni_pattern.sv
      - verilog/riu2_combine.sv
      - verilog/lbp_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/lbp_tb.sv
